// ==== verif/boot_testdata.txt ====
// boot image first: 16 words, loaded from address 0 upward
// then host records: op (1 write, 0 read) addr wdata be expected_rdata
00000013 DEADBEEF 12345678 80000000
FFFFFFFF 0BADF00D 76543210 A5A5A5A5
00C0FFEE 13579BDF 2468ACE0 F0F0F0F0
0000FFFF 7FFFFFFF C001D00D 55AA55AA
// full word, then byte merges at 0x100
1 00000100 11223344 F 00000000
0 00000100 00000000 0 11223344
1 00000100 AABBCCDD 5 00000000
0 00000100 00000000 0 11BB33DD
1 00000100 99887766 8 00000000
0 00000100 00000000 0 99BB33DD
1 00000104 FFFFFFFF F 00000000
1 00000104 0000CAFE 3 00000000
0 00000104 00000000 0 FFFFCAFE
// upper address bits dropped by the 26-bit port
1 FC000200 5A5A0001 F 00000000
0 00000200 00000000 0 5A5A0001
0 04000200 00000000 0 5A5A0001
// boot image and zero region seen from the host
0 00000008 00000000 0 12345678
0 00000080 00000000 0 00000000

// ==== build.f ====
hw/boot_pkg.sv
hw/boot_sequencer.sv
hw/word_addr_counter.sv
hw/mem_access_engine.sv
hw/image_checksum.sv
hw/mem_port_mux.sv
hw/mem_boot_top.sv
verif/mem_model.sv
verif/tb_mem_boot.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_boot
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator and run it, log in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test: failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test: no result in $(LOG)"; exit 1; \
	else \
		echo "test: passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_mem_boot.sv ====
// testbench for the memory boot block
// loads the image from the test data file, probes the host port during boot,
// then checks memory, checksum and a list of host accesses
`timescale 1ns/1ps

module tb_mem_boot;
    import boot_pkg::*;

    localparam int    RESET_CYCLES   = 16;
    localparam int    HOST_RECS      = 14;
    localparam int    REC_FIELDS     = 5;   // op, addr, wdata, be, expected rdata
    localparam int    DATA_WORDS     = LOAD_WORDS + HOST_RECS * REC_FIELDS;
    localparam int    TIMEOUT_CYCLES = (ZERO_WORDS + 2 * LOAD_WORDS + HOST_RECS) * 8
                                       + RESET_CYCLES;
    localparam addr_t PROBE_ADDR     = 26'h000_0300;   // above the zero region
    localparam word_t PROBE_DATA     = 32'hFEED_FACE;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       load_we;
    word_t      load_data;
    logic       load_ready;
    mem_req_t   host_req;
    mem_rsp_t   host_rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    logic       init_done;
    logic       checksum_match;
    word_t      load_checksum;
    logic [2:0] busy_len = 3'd1;
    word_t      fill_seed;

    word_t tdata [0:DATA_WORDS-1];
    int    mismatches   = 0;
    int    other_errors = 0;
    int    cycles       = 0;

    always #2 clk = ~clk;

    mem_boot_top dut (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_load_we        (load_we),
        .i_load_data      (load_data),
        .o_load_ready     (load_ready),
        .i_host           (host_req),
        .o_host_rsp       (host_rsp),
        .o_mem_req        (mem_req),
        .i_mem_rsp        (mem_rsp),
        .o_init_done      (init_done),
        .o_checksum_match (checksum_match),
        .o_load_checksum  (load_checksum)
    );

    mem_model u_mem (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_req       (mem_req),
        .i_busy_len  (busy_len),
        .i_fill_seed (fill_seed),
        .o_rsp       (mem_rsp)
    );

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // image words when ready, stray pulses every other cycle when not
    task automatic run_loader();
        int   idx;
        logic stray;
        idx   = 0;
        stray = 1'b0;
        while (!init_done) begin
            @(negedge clk);
            load_we = 1'b0;
            if (load_ready && idx < LOAD_WORDS) begin
                load_we   = 1'b1;
                load_data = tdata[idx];
                idx++;
            end else if (!load_ready) begin
                stray = !stray;
                if (stray) begin
                    load_we   = 1'b1;
                    load_data = 32'hBAD0_0000 | 32'(idx);   // must never land
                end
            end
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    // host holds a write strobe for the whole boot
    task automatic probe_host_during_boot();
        @(negedge clk);
        host_req.rd    = 1'b0;
        host_req.wr    = 1'b1;
        host_req.addr  = PROBE_ADDR;
        host_req.wdata = PROBE_DATA;
        host_req.be    = 4'hF;
        while (!init_done)
            @(negedge clk);
        host_req = '0;
    endtask

    task automatic host_access(input logic write, input word_t addr, input word_t wdata,
                               input be_t be, output word_t rdata);
        @(negedge clk);
        host_req.rd    = !write;
        host_req.wr    = write;
        host_req.addr  = addr_t'(addr);   // bits above 25 fall off here
        host_req.wdata = wdata;
        host_req.be    = be;
        @(negedge clk);
        while (!host_rsp.busy)
            @(negedge clk);
        host_req.rd = 1'b0;
        host_req.wr = 1'b0;
        @(negedge clk);
        while (host_rsp.busy)
            @(negedge clk);
        rdata = host_rsp.rdata;
    endtask

    always @(negedge clk)
        busy_len = 3'($urandom_range(1, 4));

    always @(negedge clk) begin
        if (rst_n && !init_done) begin
            compare_word("o_host_rsp.busy", 32'(host_rsp.busy), 32'd1);
            if ((mem_req.rd || mem_req.wr) && mem_req.addr >= ZERO_END) begin
                other_errors++;
                $display("ERROR t=%0t host request reached the memory port during boot", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("ERROR: run still busy after %0d cycles, boot or host access stuck",
                     TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        word_t rdata;
        word_t exp_word;
        word_t sum;
        int    base;
        void'($urandom(92266));
        fill_seed = $urandom();
        rst_n     = 1'b0;
        load_we   = 1'b0;
        load_data = '0;
        host_req  = '0;
        $readmemh("verif/boot_testdata.txt", tdata);
        foreach (tdata[i]) begin
            if ($isunknown(tdata[i])) begin
                other_errors++;
                $display("ERROR: test data word %0d is missing from the data file", i);
            end
        end

        repeat (RESET_CYCLES) @(negedge clk);
        compare_word("o_mem_req.rd", 32'(mem_req.rd), 32'd0);   // still in reset here
        compare_word("o_mem_req.wr", 32'(mem_req.wr), 32'd0);
        compare_word("o_init_done", 32'(init_done), 32'd0);
        compare_word("o_checksum_match", 32'(checksum_match), 32'd0);
        compare_word("o_load_ready", 32'(load_ready), 32'd0);
        compare_word("o_host_rsp.busy", 32'(host_rsp.busy), 32'd1);
        rst_n = 1'b1;

        fork
            run_loader();
            probe_host_during_boot();
        join

        for (int i = 0; i < ZERO_WORDS; i++) begin
            exp_word = (i < LOAD_WORDS) ? tdata[i] : '0;
            compare_word($sformatf("mem[%0d]", i), u_mem.mem[i], exp_word);
        end
        sum = '0;
        for (int i = 0; i < LOAD_WORDS; i++)
            sum = sum + tdata[i];   // wraps at 32 bits
        compare_word("o_load_checksum", load_checksum, sum);
        compare_word("o_checksum_match", 32'(checksum_match), 32'd1);

        for (int r = 0; r < HOST_RECS; r++) begin
            base = LOAD_WORDS + r * REC_FIELDS;
            host_access(tdata[base][0], tdata[base + 1], tdata[base + 2],
                        be_t'(tdata[base + 3]), rdata);
            if (!tdata[base][0])
                compare_word($sformatf("o_host_rsp.rdata @%h", tdata[base + 1]),
                             rdata, tdata[base + 4]);
        end

        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verif/mem_model.sv ====
// behavioral DRAM request port for the testbench
// busy rises one cycle after a strobe, stays high i_busy_len cycles, then falls
// unwritten words read back a seed scrambled with the word address
`timescale 1ns/1ps

module mem_model (
    input  logic               clk,
    input  logic               i_rst_n,
    input  boot_pkg::mem_req_t i_req,
    input  logic [2:0]         i_busy_len,
    input  boot_pkg::word_t    i_fill_seed,
    output boot_pkg::mem_rsp_t o_rsp
);
    import boot_pkg::*;

    localparam int MEM_WORDS = 256;   // 1 KB, covers every test address

    word_t                mem [0:MEM_WORDS-1];
    logic [MEM_WORDS-1:0] written;
    mem_req_t             req;       // access being served
    logic                 busy;
    logic [2:0]           cnt;
    logic                 finish;
    logic [7:0]           idx;
    word_t                cur;
    word_t                merged;
    word_t                rdata;

    assign idx    = req.addr[9:2];
    assign finish = busy && (cnt <= 3'd1);   // last busy cycle
    assign cur    = written[idx] ? mem[idx] : (i_fill_seed ^ (32'(idx) * 32'h9E37_79B9));

    always_comb begin
        merged = cur;
        for (int b = 0; b < 4; b++) begin
            if (req.be[b])
                merged[8*b +: 8] = req.wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            cnt     <= 3'd0;
            req     <= '0;
            written <= '0;
        end else if (!busy) begin
            if (i_req.rd || i_req.wr) begin
                busy <= 1'b1;
                cnt  <= i_busy_len;
                req  <= i_req;   // requester drops the strobe once it sees busy
            end
        end else if (finish) begin
            busy <= 1'b0;
            if (req.wr)
                written[idx] <= 1'b1;
        end else begin
            cnt <= cnt - 3'd1;
        end
    end

    // data side commits on the falling edge of busy
    always_ff @(posedge clk) begin
        if (i_rst_n && finish) begin
            if (req.rd)
                rdata <= cur;
            if (req.wr)
                mem[idx] <= merged;
        end
    end

    assign o_rsp.busy  = busy;
    assign o_rsp.rdata = rdata;   // valid in the cycle busy is low again

endmodule

// ==== hw/mem_boot_top.sv ====
// memory boot block: zero fill, image load, verify, then host pass-through
// sits between the host and the DRAM controller request port
`timescale 1ns/1ps

module mem_boot_top (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_load_we,
    input  boot_pkg::word_t    i_load_data,
    output logic               o_load_ready,
    input  boot_pkg::mem_req_t i_host,
    output boot_pkg::mem_rsp_t o_host_rsp,
    output boot_pkg::mem_req_t o_mem_req,
    input  boot_pkg::mem_rsp_t i_mem_rsp,
    output logic               o_init_done,
    output logic               o_checksum_match,
    output boot_pkg::word_t    o_load_checksum
);
    import boot_pkg::*;

    init_phase_t phase;
    logic        start;
    logic        at_end;
    logic        access_done;
    addr_t       boot_addr;
    mem_req_t    boot_req;

    boot_sequencer u_seq (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_at_end      (at_end),
        .i_access_done (access_done),
        .i_load_we     (i_load_we),
        .o_phase       (phase),
        .o_start       (start),
        .o_load_ready  (o_load_ready),
        .o_init_done   (o_init_done)
    );

    word_addr_counter u_addr (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_phase  (phase),
        .i_step   (access_done),
        .o_addr   (boot_addr),
        .o_at_end (at_end)
    );

    mem_access_engine u_engine (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (start),
        .i_phase     (phase),
        .i_addr      (boot_addr),
        .i_load_data (i_load_data),
        .i_mem_rsp   (i_mem_rsp),
        .o_req       (boot_req),
        .o_done      (access_done),
        .o_idle      ()             // checked inside the engine only
    );

    image_checksum u_sum (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_phase      (phase),
        .i_load_add   (start),
        .i_load_data  (i_load_data),
        .i_verify_add (access_done),
        .i_rdata      (i_mem_rsp.rdata),
        .o_load_sum   (o_load_checksum),
        .o_match      (o_checksum_match)
    );

    mem_port_mux u_mux (
        .i_phase    (phase),
        .i_boot_req (boot_req),
        .i_host_req (i_host),
        .i_mem_rsp  (i_mem_rsp),
        .o_mem_req  (o_mem_req),
        .o_host_rsp (o_host_rsp)
    );

endmodule

// ==== hw/mem_port_mux.sv ====
// owner select for the memory port
// boot engine drives it until run mode, the host only afterwards
`timescale 1ns/1ps

module mem_port_mux (
    input  boot_pkg::init_phase_t i_phase,
    input  boot_pkg::mem_req_t    i_boot_req,
    input  boot_pkg::mem_req_t    i_host_req,
    input  boot_pkg::mem_rsp_t    i_mem_rsp,
    output boot_pkg::mem_req_t    o_mem_req,
    output boot_pkg::mem_rsp_t    o_host_rsp
);
    import boot_pkg::*;

    logic run;

    assign run = (i_phase == PH_RUN);

    always_comb begin
        if (run) begin
            o_mem_req.rd    = i_host_req.rd;
            o_mem_req.wr    = i_host_req.wr;
            o_mem_req.addr  = i_host_req.addr;    // addr_t field keeps bits 25:0 only
            o_mem_req.wdata = i_host_req.wdata;
            o_mem_req.be    = i_host_req.be;      // byte enables untouched
        end else begin
            o_mem_req = i_boot_req;   // host strobes never reach the port here
        end
    end

    always_comb begin
        if (run) begin
            o_host_rsp = i_mem_rsp;
        end else begin
            // host stalls for the whole boot
            o_host_rsp.busy  = 1'b1;
            o_host_rsp.rdata = '0;
        end
    end

endmodule

// ==== hw/image_checksum.sv ====
// running sums of the boot image as loaded and as read back
// the match flag is only meaningful once boot has reached run mode
`timescale 1ns/1ps

module image_checksum (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  boot_pkg::init_phase_t i_phase,
    input  logic                  i_load_add,
    input  boot_pkg::word_t       i_load_data,
    input  logic                  i_verify_add,
    input  boot_pkg::word_t       i_rdata,
    output boot_pkg::word_t       o_load_sum,
    output logic                  o_match
);
    import boot_pkg::*;

    word_t load_sum;
    word_t verify_sum;

    // both wrap modulo 2^32
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_sum   <= '0;
            verify_sum <= '0;
        end else begin
            if (i_load_add && i_phase == PH_LOAD)
                load_sum <= load_sum + i_load_data;     // accepted loader word
            if (i_verify_add && i_phase == PH_VERIFY)
                verify_sum <= verify_sum + i_rdata;     // readback word
        end
    end

    assign o_load_sum = load_sum;
    assign o_match    = (i_phase == PH_RUN) && (load_sum == verify_sum);

endmodule

// ==== hw/mem_access_engine.sv ====
// runs a single boot access on the memory port
// strobe until busy rises, then wait for busy to fall and pulse done
`timescale 1ns/1ps

module mem_access_engine (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  boot_pkg::init_phase_t i_phase,
    input  boot_pkg::addr_t       i_addr,
    input  boot_pkg::word_t       i_load_data,
    input  boot_pkg::mem_rsp_t    i_mem_rsp,
    output boot_pkg::mem_req_t    o_req,
    output logic                  o_done,
    output logic                  o_idle
);
    import boot_pkg::*;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_REQ,    // strobe held, waiting for busy high
        ENG_WAIT    // strobe dropped, waiting for busy low
    } eng_state_t;

    eng_state_t state;
    logic       r_read;
    addr_t      r_addr;
    word_t      r_wdata;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ENG_IDLE;
        end else begin
            case (state)
                ENG_IDLE: if (i_start) state <= ENG_REQ;
                ENG_REQ:  if (i_mem_rsp.busy) state <= ENG_WAIT;
                ENG_WAIT: if (!i_mem_rsp.busy) state <= ENG_IDLE;
                default:  state <= ENG_IDLE;
            endcase
        end
    end

    // access details captured at start, held for the whole access
    always_ff @(posedge clk) begin
        if (i_start) begin
            r_read  <= (i_phase == PH_VERIFY);
            r_addr  <= i_addr;
            r_wdata <= (i_phase == PH_LOAD) ? i_load_data : '0;
        end
    end

    always_comb begin
        o_req.rd    = (state == ENG_REQ) && r_read;
        o_req.wr    = (state == ENG_REQ) && !r_read;
        o_req.addr  = r_addr;
        o_req.wdata = r_wdata;
        o_req.be    = BE_ALL;
    end

    assign o_done = (state == ENG_WAIT) && !i_mem_rsp.busy;   // rdata valid here
    assign o_idle = (state == ENG_IDLE);

    // a new strobe only once the port is quiet again
    a_one_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(o_req.rd || o_req.wr) |-> !i_mem_rsp.busy);

    // sequencer keeps its own in-flight view, must agree with ours
    a_start_when_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start |-> o_idle);

endmodule

// ==== hw/word_addr_counter.sv ====
// word address for the boot accesses, one step per finished access
// restarts at zero on every phase change and flags the end of the region
`timescale 1ns/1ps

module word_addr_counter (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  boot_pkg::init_phase_t i_phase,
    input  logic                  i_step,
    output boot_pkg::addr_t       o_addr,
    output logic                  o_at_end
);
    import boot_pkg::*;

    init_phase_t r_phase;   // phase seen last cycle
    addr_t       addr;
    addr_t       limit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_phase <= PH_RESET;
            addr    <= '0;
        end else begin
            r_phase <= i_phase;
            if (i_phase != r_phase)
                addr <= '0;   // new phase starts at the bottom
            else if (i_step)
                addr <= addr + addr_t'(WORD_BYTES);
        end
    end

    always_comb begin
        case (i_phase)
            PH_ZERO:             limit = ZERO_END;
            PH_LOAD, PH_VERIFY:  limit = LOAD_END;
            default:             limit = '0;   // nothing to walk
        endcase
    end

    assign o_addr   = addr;
    assign o_at_end = (addr >= limit);

    a_no_step_at_end: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_step |-> !o_at_end);

endmodule

// ==== hw/boot_sequencer.sv ====
// boot phase FSM: zero fill, image load, verify readback, then run
// starts one memory access at a time and hands the port to the host at the end
`timescale 1ns/1ps

module boot_sequencer (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_at_end,
    input  logic                  i_access_done,
    input  logic                  i_load_we,
    output boot_pkg::init_phase_t o_phase,
    output logic                  o_start,
    output logic                  o_load_ready,
    output logic                  o_init_done
);
    import boot_pkg::*;

    init_phase_t phase;
    init_phase_t phase_nxt;
    logic        in_flight;   // an access is out at the engine
    logic        fresh;       // first cycle of a phase, counter still clearing
    logic        phase_end;

    // end of a phase counts only once the last access has finished
    assign phase_end = i_at_end && !in_flight && !fresh;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_RESET:  phase_nxt = PH_ZERO;
            PH_ZERO:   if (phase_end) phase_nxt = PH_LOAD;
            PH_LOAD:   if (phase_end) phase_nxt = PH_VERIFY;
            PH_VERIFY: if (phase_end) phase_nxt = PH_RUN;
            default:   phase_nxt = phase;   // run is final
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= PH_RESET;
            fresh     <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            phase <= phase_nxt;
            fresh <= (phase_nxt != phase);
            if (o_start)
                in_flight <= 1'b1;
            else if (i_access_done)
                in_flight <= 1'b0;
        end
    end

    // loader may hand over a word only when the engine can take it
    assign o_load_ready = (phase == PH_LOAD) && !in_flight && !i_at_end && !fresh;

    always_comb begin
        o_start = 1'b0;
        if (phase == PH_ZERO || phase == PH_VERIFY)
            o_start = !in_flight && !i_at_end && !fresh;   // free running
        else if (phase == PH_LOAD)
            o_start = i_load_we && o_load_ready;           // paced by the loader
    end

    assign o_phase     = phase;
    assign o_init_done = (phase == PH_RUN);

    // host traffic owns the port in run mode
    a_no_start_in_run: assert property (@(posedge clk) disable iff (!i_rst_n)
        phase == PH_RUN |-> !o_start && !i_access_done);

    a_phase_forward: assert property (@(posedge clk) disable iff (!i_rst_n)
        phase >= $past(phase));

endmodule

// ==== hw/boot_pkg.sv ====
// shared types and sizes for the memory boot block
// imported by every RTL module and by the testbench
package boot_pkg;

    typedef logic [31:0] word_t;   // memory data word
    typedef logic [25:0] addr_t;   // byte address, same range as the controller
    typedef logic [3:0]  be_t;     // byte enables

    // boot phases, in the order they run
    typedef enum logic [2:0] {
        PH_RESET,
        PH_ZERO,
        PH_LOAD,
        PH_VERIFY,
        PH_RUN
    } init_phase_t;

    // request side of the memory port
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } mem_req_t;

    // response side of the memory port
    typedef struct packed {
        logic  busy;    // falling edge ends an access
        word_t rdata;   // valid when busy falls after a read
    } mem_rsp_t;

    localparam int WORD_BYTES = 4;    // address step per word
    localparam int ZERO_WORDS = 64;   // working region cleared at boot
    localparam int LOAD_WORDS = 16;   // boot image length

    // byte limits of the zero and load regions
    localparam addr_t ZERO_END = addr_t'(ZERO_WORDS * WORD_BYTES);
    localparam addr_t LOAD_END = addr_t'(LOAD_WORDS * WORD_BYTES);

    localparam be_t BE_ALL = 4'b1111;   // full word writes during boot

endpackage
